//--- logic/regfile_settings.svh
`ifndef REGFILE_SETTINGS_SVH
`define REGFILE_SETTINGS_SVH

// width of one register word.
`define RF_DATA_W 8

// register address width.
`define RF_ADDR_W 2

// number of registers in the file.
`define RF_DEPTH 4

// width of one host instruction word.
`define RF_INSTR_W 12

`endif

//--- logic/regfile_pkg.sv
`include "regfile_settings.svh"

package regfile_pkg;

    typedef enum logic [1:0] {
        op_add,
        op_sub,
        op_and,
        op_xor
    } alu_op_t;

    typedef enum logic {
        kind_alu,
        kind_load
    } instr_kind_t;

    typedef struct packed {
        instr_kind_t           kind;      // top bit, shared with the load form.
        alu_op_t               op;
        logic [`RF_ADDR_W-1:0] dst;
        logic [`RF_ADDR_W-1:0] src_l;
        logic [`RF_ADDR_W-1:0] src_r;
        logic [2:0]            spare;
    } alu_form_t;

    typedef struct packed {
        instr_kind_t           kind;      // same position as in the alu form.
        logic [`RF_ADDR_W-1:0] dst;
        logic                  spare;
        logic [`RF_DATA_W-1:0] imm;
    } load_form_t;

    typedef union packed {
        alu_form_t  alu;
        load_form_t load;
    } instr_u;

    typedef struct packed {
        logic [`RF_ADDR_W-1:0] addr;
        logic [`RF_DATA_W-1:0] data;
    } wr_req_t;

    typedef struct packed {
        logic                  valid;     // set in a cycle where the file stores data.
        logic [`RF_ADDR_W-1:0] addr;
        logic [`RF_DATA_W-1:0] data;
    } wr_event_t;

endpackage

//--- logic/dual_port_regfile.sv
`timescale 1ns/1ns
`include "regfile_settings.svh"

module dual_port_regfile
    import regfile_pkg::*;
(
    input  logic                  _wr_en,
    input  logic                  rst,
    input  wr_event_t             rf_wr,
    input  logic [`RF_ADDR_W-1:0] rd_l_addr,
    input  logic [`RF_ADDR_W-1:0] rd_r_addr,
    output logic [`RF_DATA_W-1:0] rd_l_data,
    output logic [`RF_DATA_W-1:0] rd_r_data
);

    logic [`RF_DATA_W-1:0] regs [`RF_DEPTH];

    always_ff @(posedge _wr_en) begin
        if (rst) begin
            for (int i = 0; i < `RF_DEPTH; i++) begin
                regs[i] <= '0;
            end
        end else if (rf_wr.valid) begin
            regs[rf_wr.addr] <= rf_wr.data;              // one shared write port.
        end
    end

    // both read ports see the stored contents, a write shows up a cycle later.
    assign rd_l_data = regs[rd_l_addr];
    assign rd_r_data = regs[rd_r_addr];

    // once the arbiter has been through one reset edge it must not offer a write.
    a_no_write_in_reset : assert property (
        @(posedge _wr_en) rst && $past(rst) |-> !rf_wr.valid
    ) else $error("register file write strobe high during reset.");

endmodule

//--- logic/write_arbiter.sv
`timescale 1ns/1ns

module write_arbiter
    import regfile_pkg::*;
(
    input  logic      _wr_en,
    input  logic      rst,
    input  logic      wr_req0,
    input  wr_req_t   wr_data0,
    input  logic      wr_req1,
    input  wr_req_t   wr_data1,
    output logic      wr_ack0,
    output logic      wr_ack1,
    output wr_event_t rf_wr,
    output wr_event_t write_event
);

    logic last_grant;                                    // high when port 1 had the last turn.
    logic idle;
    logic grant0;
    logic grant1;

    assign idle   = !wr_ack0 && !wr_ack1;                // no handshake still open.
    assign grant0 = idle && wr_req0 && (!wr_req1 || last_grant);
    assign grant1 = idle && wr_req1 && (!wr_req0 || !last_grant);

    always_comb begin
        rf_wr.valid = grant0 || grant1;
        rf_wr.addr  = grant1 ? wr_data1.addr : wr_data0.addr;
        rf_wr.data  = grant1 ? wr_data1.data : wr_data0.data;
    end

    always_ff @(posedge _wr_en) begin
        if (rst) begin
            wr_ack0     <= 1'b0;
            wr_ack1     <= 1'b0;
            last_grant  <= 1'b0;
            write_event <= '0;
        end else begin
            if (grant0) begin
                wr_ack0    <= 1'b1;
                last_grant <= 1'b0;
            end else if (!wr_req0) begin
                wr_ack0 <= 1'b0;                         // peer has let go of its request.
            end
            if (grant1) begin
                wr_ack1    <= 1'b1;
                last_grant <= 1'b1;
            end else if (!wr_req1) begin
                wr_ack1 <= 1'b0;
            end
            write_event <= rf_wr;                        // what the file stored on this edge.
        end
    end

    a_acks_exclusive : assert property (
        @(posedge _wr_en) disable iff (rst) !(wr_ack0 && wr_ack1)
    ) else $error("both write acks high together.");

    a_ack0_follows_req : assert property (
        @(posedge _wr_en) disable iff (rst) $rose(wr_ack0) |-> $past(wr_req0)
    ) else $error("write ack 0 rose without a pending request.");

    a_ack1_follows_req : assert property (
        @(posedge _wr_en) disable iff (rst) $rose(wr_ack1) |-> $past(wr_req1)
    ) else $error("write ack 1 rose without a pending request.");

endmodule

//--- logic/alu_unit.sv
`timescale 1ns/1ns
`include "regfile_settings.svh"

module alu_unit
    import regfile_pkg::*;
(
    input  logic                  _wr_en,
    input  logic                  rst,
    input  logic                  exec_req,
    input  alu_form_t             exec_instr,
    input  logic [`RF_DATA_W-1:0] rd_l_data,
    input  logic [`RF_DATA_W-1:0] rd_r_data,
    input  logic                  wr_ack1,
    output logic                  exec_ack,
    output logic [`RF_ADDR_W-1:0] rd_l_addr,
    output logic [`RF_ADDR_W-1:0] rd_r_addr,
    output logic                  wr_req1,
    output wr_req_t               wr_data1
);

    typedef enum logic [1:0] {
        st_idle,
        st_write,
        st_done
    } alu_state_t;

    alu_state_t            state;
    logic                  start;
    logic [`RF_DATA_W-1:0] result;

    // operands come straight from the register file while the request is held.
    assign rd_l_addr = exec_instr.src_l;
    assign rd_r_addr = exec_instr.src_r;

    always_comb begin
        case (exec_instr.op)
            op_add:  result = rd_l_data + rd_r_data;     // wraps at 256.
            op_sub:  result = rd_l_data - rd_r_data;
            op_and:  result = rd_l_data & rd_r_data;
            default: result = rd_l_data ^ rd_r_data;     // op_xor.
        endcase
    end

    // the previous write handshake must be fully closed before a new one starts.
    assign start = (state == st_idle) && exec_req && !wr_ack1;

    always_ff @(posedge _wr_en) begin
        if (rst) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle:  if (start) state <= st_write;
                st_write: if (wr_ack1) state <= st_done;
                st_done:  if (!exec_req) state <= st_idle;
                default:  state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge _wr_en) begin
        if (start) begin
            wr_data1.addr <= exec_instr.dst;             // result is captured with its target.
            wr_data1.data <= result;
        end
    end

    assign wr_req1  = (state == st_write);
    assign exec_ack = (state == st_done);

    // the host port keeps the request up until the result has been written.
    a_exec_req_held : assert property (
        @(posedge _wr_en) disable iff (rst) $fell(exec_req) |-> exec_ack
    ) else $error("exec_req dropped before exec_ack.");

endmodule

//--- logic/host_port.sv
`timescale 1ns/1ns

module host_port
    import regfile_pkg::*;
(
    input  logic      _wr_en,
    input  logic      rst,
    input  logic      host_req,
    input  instr_u    host_instr,
    input  logic      exec_ack,
    input  logic      wr_ack0,
    output logic      host_ack,
    output logic      exec_req,
    output alu_form_t exec_instr,
    output logic      wr_req0,
    output wr_req_t   wr_data0
);

    typedef enum logic [1:0] {
        st_idle,
        st_load,
        st_alu,
        st_ack
    } host_state_t;

    host_state_t state;
    instr_u      instr_q;
    logic        start;

    // both downstream handshakes have to be back to idle before a new word is taken.
    assign start = (state == st_idle) && host_req && !wr_ack0 && !exec_ack;

    always_ff @(posedge _wr_en) begin
        if (rst) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (start) begin
                        if (host_instr.alu.kind == kind_load) begin
                            state <= st_load;
                        end else begin
                            state <= st_alu;
                        end
                    end
                end
                st_load: if (wr_ack0) state <= st_ack;      // immediate is in the file.
                st_alu:  if (exec_ack) state <= st_ack;     // alu result is in the file.
                st_ack:  if (!host_req) state <= st_idle;
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge _wr_en) begin
        if (start) begin
            instr_q <= host_instr;
        end
    end

    assign host_ack   = (state == st_ack);
    assign wr_req0    = (state == st_load);
    assign exec_req   = (state == st_alu);
    assign exec_instr = instr_q.alu;
    assign wr_data0.addr = instr_q.load.dst;
    assign wr_data0.data = instr_q.load.imm;

endmodule

//--- logic/regfile_top.sv
`timescale 1ns/1ns
`include "regfile_settings.svh"

module regfile_top
    import regfile_pkg::*;
(
    input  logic      _wr_en,
    input  logic      rst,
    input  logic      host_req,
    input  instr_u    host_instr,
    output logic      host_ack,
    output wr_event_t write_event
);

    logic                  exec_req;
    logic                  exec_ack;
    alu_form_t             exec_instr;
    logic                  wr_req0;
    logic                  wr_ack0;
    wr_req_t               wr_data0;
    logic                  wr_req1;
    logic                  wr_ack1;
    wr_req_t               wr_data1;
    wr_event_t             rf_wr;
    logic [`RF_ADDR_W-1:0] rd_l_addr;
    logic [`RF_ADDR_W-1:0] rd_r_addr;
    logic [`RF_DATA_W-1:0] rd_l_data;
    logic [`RF_DATA_W-1:0] rd_r_data;

    host_port i_host_port (
        ._wr_en     (_wr_en),
        .rst        (rst),
        .host_req   (host_req),
        .host_instr (host_instr),
        .exec_ack   (exec_ack),
        .wr_ack0    (wr_ack0),
        .host_ack   (host_ack),
        .exec_req   (exec_req),
        .exec_instr (exec_instr),
        .wr_req0    (wr_req0),
        .wr_data0   (wr_data0)
    );

    alu_unit i_alu_unit (
        ._wr_en     (_wr_en),
        .rst        (rst),
        .exec_req   (exec_req),
        .exec_instr (exec_instr),
        .rd_l_data  (rd_l_data),
        .rd_r_data  (rd_r_data),
        .wr_ack1    (wr_ack1),
        .exec_ack   (exec_ack),
        .rd_l_addr  (rd_l_addr),
        .rd_r_addr  (rd_r_addr),
        .wr_req1    (wr_req1),
        .wr_data1   (wr_data1)
    );

    write_arbiter i_write_arbiter (
        ._wr_en      (_wr_en),
        .rst         (rst),
        .wr_req0     (wr_req0),
        .wr_data0    (wr_data0),
        .wr_req1     (wr_req1),
        .wr_data1    (wr_data1),
        .wr_ack0     (wr_ack0),
        .wr_ack1     (wr_ack1),
        .rf_wr       (rf_wr),
        .write_event (write_event)
    );

    dual_port_regfile i_regfile (
        ._wr_en    (_wr_en),
        .rst       (rst),
        .rf_wr     (rf_wr),
        .rd_l_addr (rd_l_addr),
        .rd_r_addr (rd_r_addr),
        .rd_l_data (rd_l_data),
        .rd_r_data (rd_r_data)
    );

endmodule

//--- tb/regfile_tb.sv
`timescale 1ns/1ns
`include "regfile_settings.svh"

module regfile_tb
    import regfile_pkg::*;
();

    localparam int N_LINES    = 28;
    localparam int MAX_CYCLES = 20 * N_LINES + 20;

    logic      _wr_en = 1'b0;
    logic      rst;
    logic      host_req;
    instr_u    host_instr;
    logic      host_ack;
    wr_event_t write_event;

    logic [`RF_INSTR_W-1:0] stim [3 * N_LINES];           // instr, addr, data for each line.
    logic [`RF_DATA_W-1:0]  model_regs [`RF_DEPTH];
    int unsigned            rng_state;
    int                     cycles;
    int                     seen_count;                  // write events since the last request.
    wr_event_t              seen_event;
    logic                   ack_prev;
    logic                   req_sent;

    regfile_top i_dut (
        ._wr_en      (_wr_en),
        .rst         (rst),
        .host_req    (host_req),
        .host_instr  (host_instr),
        .host_ack    (host_ack),
        .write_event (write_event)
    );

    always #50 _wr_en = ~_wr_en;

    task automatic report_failure();
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped at the first error.");
    endtask

    task automatic check_event(input wr_event_t actual, input wr_event_t expected,
                               input string name);
        if (actual !== expected) begin
            $write("Mismatch at %0t ns: %s is valid %b addr %0d data %h", $time, name,
                   actual.valid, actual.addr, actual.data);
            $display(", expected valid %b addr %0d data %h", expected.valid, expected.addr,
                     expected.data);
            report_failure();
        end
    endtask

    task automatic check_ack(input logic actual, input logic expected, input string name);
        if (actual !== expected) begin
            $display("Mismatch at %0t ns: %s is %b, expected %b", $time, name, actual, expected);
            report_failure();
        end
    endtask

    task automatic check_count(input int actual, input int expected, input string name);
        if (actual != expected) begin
            $display("Mismatch at %0t ns: %s is %0d, expected %0d", $time, name, actual, expected);
            report_failure();
        end
    endtask

    function automatic int unsigned next_rand();
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return rng_state >> 16;                          // low bits of an lcg repeat too soon.
    endfunction

    // the value the reference model expects the instruction to write.
    function automatic wr_event_t predict_write(input instr_u word);
        wr_event_t ev;
        logic [`RF_DATA_W-1:0] a;
        logic [`RF_DATA_W-1:0] b;
        a = model_regs[word.alu.src_l];
        b = model_regs[word.alu.src_r];
        ev.valid = 1'b1;
        if (word.load.kind == kind_load) begin
            ev.addr = word.load.dst;
            ev.data = word.load.imm;
        end else begin
            ev.addr = word.alu.dst;
            case (word.alu.op)
                op_add:  ev.data = a + b;
                op_sub:  ev.data = a - b;                // wraps modulo 256.
                op_and:  ev.data = a & b;
                default: ev.data = a ^ b;
            endcase
        end
        return ev;
    endfunction

    // waits for the falling edge, where every DUT output is settled, and watches them.
    task automatic step();
        @(negedge _wr_en);
        cycles++;
        if (cycles > MAX_CYCLES) begin
            $display("Timeout: the handshakes did not finish within %0d cycles.", MAX_CYCLES);
            report_failure();
        end
        if (!req_sent) begin
            check_ack(host_ack, 1'b0, "host_ack");
            check_ack(write_event.valid, 1'b0, "write_event.valid");
        end
        if (write_event.valid) begin
            seen_count++;
            seen_event = write_event;
        end
        if (host_ack && !ack_prev) check_ack(host_req, 1'b1, "host_req at host_ack rise");
        if (!host_ack && ack_prev) check_ack(host_req, 1'b0, "host_req at host_ack fall");
        ack_prev = host_ack;
    endtask

    initial begin
        instr_u    word;
        wr_event_t expected;
        wr_event_t from_file;
        int        gap;
        rst        = 1'b1;
        host_req   = 1'b0;
        host_instr = '0;
        rng_state  = 27;
        cycles     = 0;
        seen_count = 0;
        seen_event = '0;
        ack_prev   = 1'b0;
        req_sent   = 1'b0;
        for (int r = 0; r < `RF_DEPTH; r++) begin
            model_regs[r] = '0;
        end
        $readmemh("tb/regfile_input.txt", stim);
        repeat (4) @(posedge _wr_en);
        rst <= 1'b0;
        repeat (3) step();
        for (int i = 0; i < N_LINES; i++) begin
            word      = stim[3 * i];
            expected  = predict_write(word);
            from_file = {1'b1, stim[3 * i + 1][`RF_ADDR_W-1:0], stim[3 * i + 2][`RF_DATA_W-1:0]};
            if (from_file !== expected) begin
                $display("Data file line %0d disagrees with the reference model.", i + 1);
                report_failure();
            end
            gap = int'(next_rand() % 4);
            repeat (gap) step();
            @(posedge _wr_en);
            host_req   <= 1'b1;
            host_instr <= word;
            req_sent   = 1'b1;
            seen_count = 0;
            do begin
                step();
            end while (!host_ack);
            check_count(seen_count, 1, "write events before host_ack");
            check_event(seen_event, expected, "write_event");
            gap = int'(next_rand() % 3);
            repeat (gap) step();
            @(posedge _wr_en);
            host_req <= 1'b0;
            do begin
                step();
            end while (host_ack);
            check_count(seen_count, 1, "write events per handshake");
            model_regs[expected.addr] = expected.data;
        end
        $display("STATUS: PASS");
        $finish;
    end

endmodule

//--- tb/regfile_input.txt
// columns: instruction word, expected write address, expected write data (all hex).
// load: bit 11 set, dst in 10:9, imm in 7:0. alu: op in 10:9, dst 8:7, src_l 6:5, src_r 4:3.
030 0 00
815 0 15
A2A 1 2A
CF0 2 F0
E07 3 07
030 0 1A
3E8 3 DD
6C0 1 EA
150 2 E0
200 0 00
208 0 16
5E8 3 C8
6A8 1 00
AFF 1 FF
0B8 1 C7
310 2 36
F80 3 80
1F8 3 00
630 0 F1
10F 2 B8
801 0 01
3E0 3 FF
1E0 3 00
4B0 1 80
C5A 2 5A
748 2 DA
230 0 A6
E3C 3 3C

//--- sim.f
+incdir+logic
logic/regfile_pkg.sv
logic/dual_port_regfile.sv
logic/write_arbiter.sv
logic/alu_unit.sv
logic/host_port.sv
logic/regfile_top.sv
tb/regfile_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module regfile_tb -o regfile_sim

status=0
out=$(./obj_dir/regfile_sim 2>&1) || status=$?
printf '%s\n' "$out"

if [ "$status" -eq 0 ] && grep -qx "STATUS: PASS" <<< "$out"; then
    exit 0
fi
exit 1
